// ==== common/l2_pkg.sv ====
// ----------------------------------------------------------
// sizes, requester ids and types for the shared L2 request path
// requester set is fixed at four, and only the data cache writes
// ----------------------------------------------------------

package l2_pkg;

    // requesters, lower id wins arbitration
    localparam int L1_CONNECTIONS = 4;
    localparam int L1_DCACHE_ID = 0;
    localparam int L1_DMMU_ID = 1;
    localparam int L1_IMMU_ID = 2;
    localparam int L1_ICACHE_ID = 3;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int L2_ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int BE_W = 4;

    // burst field holds word count minus one
    localparam int BURST_W = 3;
    localparam int SUB_ID_W = 2;

    // memory depth in words, upper word address bits are ignored
    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

    // queue depths, powers of two
    localparam int REQ_FIFO_DEPTH = 4;
    localparam int DATA_FIFO_DEPTH = 4;

    // packed request word, msb first: addr, rnw, be, burst, sub id
    localparam int L2_REQ_W = L2_ADDR_W + 1 + BE_W + BURST_W + SUB_ID_W;

    typedef logic [L2_ADDR_W-1:0] l2_addr_t;
    typedef logic [DATA_W-1:0] l2_data_t;
    typedef logic [BE_W-1:0] l2_be_t;
    typedef logic [BURST_W-1:0] burst_t;
    typedef logic [SUB_ID_W-1:0] sub_id_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_READ,
        MEM_WRITE
    } mem_state_t;

endpackage

// ==== hdl/l1_request_port.sv ====
// ----------------------------------------------------------
// purely combinational, no clock or reset ports
// writes are always a single word, the size input is ignored
// ----------------------------------------------------------
`timescale 1ns/1ps

module l1_request_port #(
    parameter int PORT_ID = 0
) (
    input  logic                        request,
    input  logic                        rnw,
    input  logic [l2_pkg::ADDR_W-1:0]   addr,
    input  l2_pkg::l2_be_t              be,
    input  l2_pkg::burst_t              size,
    input  l2_pkg::l2_data_t            rd_data,
    input  logic                        rd_data_valid,
    input  l2_pkg::sub_id_t             rd_sub_id,
    output logic                        l2_request,
    output l2_pkg::l2_addr_t            l2_addr,
    output logic                        l2_rnw,
    output l2_pkg::l2_be_t              l2_be,
    output l2_pkg::burst_t              l2_burst,
    output l2_pkg::sub_id_t             l2_sub_id,
    output logic                        data_valid,
    output l2_pkg::l2_data_t            data
);

    logic beat_match;

    assign l2_request = request;

    // word address, byte offset bits dropped
    assign l2_addr = addr[l2_pkg::ADDR_W-1:l2_pkg::ADDR_W-l2_pkg::L2_ADDR_W];
    assign l2_rnw = rnw;
    assign l2_be = be;

    // write bursts not supported
    assign l2_burst = rnw ? size : '0;
    assign l2_sub_id = l2_pkg::sub_id_t'(PORT_ID);

    // return stream is broadcast, keep only beats tagged with our id
    assign beat_match = rd_data_valid & (rd_sub_id == l2_pkg::sub_id_t'(PORT_ID));
    assign data_valid = beat_match;

    // zero outside our beats so the top can merge all ports onto one bus
    assign data = beat_match ? rd_data : '0;

endmodule

// ==== l1_arbiter/l1_arbiter.sv ====
// ----------------------------------------------------------
// fixed priority, lowest index wins, ack is combinational
// assumes the data cache is the only writer
// ----------------------------------------------------------
`timescale 1ns/1ps

module l1_arbiter (
    input  logic [l2_pkg::L1_CONNECTIONS-1:0]                   requests,
    input  l2_pkg::l2_addr_t [l2_pkg::L1_CONNECTIONS-1:0]       port_addr,
    input  logic [l2_pkg::L1_CONNECTIONS-1:0]                   port_rnw,
    input  l2_pkg::l2_be_t [l2_pkg::L1_CONNECTIONS-1:0]         port_be,
    input  l2_pkg::burst_t [l2_pkg::L1_CONNECTIONS-1:0]         port_burst,
    input  l2_pkg::sub_id_t [l2_pkg::L1_CONNECTIONS-1:0]        port_sub_id,
    input  l2_pkg::l2_data_t                                    wr_data_in,
    input  logic                                                request_full,
    input  logic                                                data_full,
    output logic [l2_pkg::L1_CONNECTIONS-1:0]                   acks,
    output logic                                                request_push,
    output logic [l2_pkg::L2_REQ_W-1:0]                         request_word,
    output logic                                                wr_data_push,
    output l2_pkg::l2_data_t                                    wr_data
);

    logic push_ready;
    logic request_exists;
    l2_pkg::sub_id_t sel;

    // the two queues drain at different rates, both need room
    assign push_ready = ~request_full & ~data_full;
    assign request_exists = |requests;

    // lowest requesting index
    always_comb begin
        sel = l2_pkg::sub_id_t'(l2_pkg::L1_CONNECTIONS - 1);
        for (int i = l2_pkg::L1_CONNECTIONS - 1; i >= 0; i--) begin
            if (requests[i]) begin
                sel = l2_pkg::sub_id_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < l2_pkg::L1_CONNECTIONS; i++) begin
            acks[i] = push_ready & requests[i] & (sel == l2_pkg::sub_id_t'(i));
        end
    end

    assign request_push = push_ready & request_exists;

    // field order must match the unpack in the memory
    assign request_word = {
        port_addr[sel],
        port_rnw[sel],
        port_be[sel],
        port_burst[sel],
        port_sub_id[sel]
    };

    // one data word per accepted dcache write
    assign wr_data_push = acks[l2_pkg::L1_DCACHE_ID] & ~port_rnw[l2_pkg::L1_DCACHE_ID];
    assign wr_data = wr_data_in;

endmodule

// ==== hdl/l2_fifo.sv ====
// ----------------------------------------------------------
// DEPTH must be a power of two, pointers wrap naturally
// push while full and pop while empty are ignored
// ----------------------------------------------------------
`timescale 1ns/1ps

module l2_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic [WIDTH-1:0]    push_data,
    input  logic                pop,
    output logic [WIDTH-1:0]    pop_data,
    output logic                full,
    output logic                empty
);

    logic [WIDTH-1:0] buffer [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic push_en;
    logic pop_en;

    assign push_en = push & ~full;
    assign pop_en = pop & ~empty;

    assign full = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign empty = (count == '0);

    // head is visible without a pop
    assign pop_data = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            buffer[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== l2_memory/l2_memory.sv ====
// ----------------------------------------------------------
// contents are not reset, write before reading
// one op at a time, read return has no back-pressure
// ----------------------------------------------------------
`timescale 1ns/1ps

module l2_memory (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [l2_pkg::L2_REQ_W-1:0]     req_word,
    input  logic                            req_empty,
    input  l2_pkg::l2_data_t                wr_word,
    input  logic                            data_empty,
    output logic                            req_pop,
    output logic                            data_pop,
    output l2_pkg::l2_data_t                rd_data,
    output logic                            rd_data_valid,
    output l2_pkg::sub_id_t                 rd_sub_id
);

    l2_pkg::l2_data_t mem [l2_pkg::MEM_WORDS];
    l2_pkg::mem_state_t state;

    // request head fields
    l2_pkg::l2_addr_t head_addr;
    logic head_rnw;
    l2_pkg::l2_be_t head_be;
    l2_pkg::burst_t head_burst;
    l2_pkg::sub_id_t head_sub_id;

    // operation in progress
    l2_pkg::l2_addr_t cur_addr;
    l2_pkg::burst_t beats_left;
    l2_pkg::sub_id_t cur_sub_id;
    l2_pkg::l2_be_t cur_be;
    l2_pkg::l2_data_t cur_data;
    logic [l2_pkg::MEM_ADDR_W-1:0] mem_index;

    assign {head_addr, head_rnw, head_be, head_burst, head_sub_id} = req_word;

    // upper word address bits wrap onto the array
    assign mem_index = cur_addr[l2_pkg::MEM_ADDR_W-1:0];

    // a write waits until its data word has arrived too
    assign req_pop = (state == l2_pkg::MEM_IDLE) & ~req_empty & (head_rnw | ~data_empty);
    assign data_pop = req_pop & ~head_rnw;

    assign rd_data = mem[mem_index];
    assign rd_data_valid = (state == l2_pkg::MEM_READ);
    assign rd_sub_id = cur_sub_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= l2_pkg::MEM_IDLE;
        end else begin
            case (state)
                l2_pkg::MEM_IDLE: begin
                    if (req_pop) begin
                        state <= head_rnw ? l2_pkg::MEM_READ : l2_pkg::MEM_WRITE;
                    end
                end
                l2_pkg::MEM_READ: begin
                    // last beat of the burst
                    if (beats_left == '0) begin
                        state <= l2_pkg::MEM_IDLE;
                    end
                end
                l2_pkg::MEM_WRITE: begin
                    state <= l2_pkg::MEM_IDLE;
                end
                default: begin
                    state <= l2_pkg::MEM_IDLE;
                end
            endcase
        end
    end

    // latch the popped request, then step through the burst
    always_ff @(posedge clk) begin
        if (req_pop) begin
            cur_addr <= head_addr;
            beats_left <= head_burst;
            cur_sub_id <= head_sub_id;
            cur_be <= head_be;
        end else if (state == l2_pkg::MEM_READ) begin
            cur_addr <= cur_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
        if (data_pop) begin
            cur_data <= wr_word;
        end
    end

    // byte lane writes
    always_ff @(posedge clk) begin
        if (state == l2_pkg::MEM_WRITE) begin
            for (int b = 0; b < l2_pkg::BE_W; b++) begin
                if (cur_be[b]) begin
                    mem[mem_index][b*8 +: 8] <= cur_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/l2_subsystem.sv ====
// ----------------------------------------------------------
// l1_wr_data is sampled only for data cache writes
// l1_rd_data is shared, qualified per port by l1_data_valid
// ----------------------------------------------------------
`timescale 1ns/1ps

module l2_subsystem (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [l2_pkg::L1_CONNECTIONS-1:0]                       l1_request,
    input  logic [l2_pkg::L1_CONNECTIONS-1:0]                       l1_rnw,
    input  logic [l2_pkg::L1_CONNECTIONS-1:0][l2_pkg::ADDR_W-1:0]   l1_addr,
    input  l2_pkg::l2_be_t [l2_pkg::L1_CONNECTIONS-1:0]             l1_be,
    input  l2_pkg::burst_t [l2_pkg::L1_CONNECTIONS-1:0]             l1_size,
    input  l2_pkg::l2_data_t                                        l1_wr_data,
    output logic [l2_pkg::L1_CONNECTIONS-1:0]                       l1_ack,
    output l2_pkg::l2_data_t                                        l1_rd_data,
    output logic [l2_pkg::L1_CONNECTIONS-1:0]                       l1_data_valid
);

    // formatted requests from the ports
    logic [l2_pkg::L1_CONNECTIONS-1:0] port_request;
    l2_pkg::l2_addr_t [l2_pkg::L1_CONNECTIONS-1:0] port_addr;
    logic [l2_pkg::L1_CONNECTIONS-1:0] port_rnw;
    l2_pkg::l2_be_t [l2_pkg::L1_CONNECTIONS-1:0] port_be;
    l2_pkg::burst_t [l2_pkg::L1_CONNECTIONS-1:0] port_burst;
    l2_pkg::sub_id_t [l2_pkg::L1_CONNECTIONS-1:0] port_sub_id;
    l2_pkg::l2_data_t [l2_pkg::L1_CONNECTIONS-1:0] port_data;

    logic request_push;
    logic [l2_pkg::L2_REQ_W-1:0] request_word;
    logic wr_data_push;
    l2_pkg::l2_data_t wr_data;

    logic [l2_pkg::L2_REQ_W-1:0] req_head;
    logic req_pop;
    logic req_full;
    logic req_empty;
    l2_pkg::l2_data_t data_head;
    logic data_pop;
    logic data_full;
    logic data_empty;

    // return stream, broadcast to every port
    l2_pkg::l2_data_t rd_data;
    logic rd_data_valid;
    l2_pkg::sub_id_t rd_sub_id;

    for (genvar i = 0; i < l2_pkg::L1_CONNECTIONS; i++) begin : g_port
        l1_request_port #(
            .PORT_ID(i)
        ) port_inst (
            .request(l1_request[i]),
            .rnw(l1_rnw[i]),
            .addr(l1_addr[i]),
            .be(l1_be[i]),
            .size(l1_size[i]),
            .rd_data(rd_data),
            .rd_data_valid(rd_data_valid),
            .rd_sub_id(rd_sub_id),
            .l2_request(port_request[i]),
            .l2_addr(port_addr[i]),
            .l2_rnw(port_rnw[i]),
            .l2_be(port_be[i]),
            .l2_burst(port_burst[i]),
            .l2_sub_id(port_sub_id[i]),
            .data_valid(l1_data_valid[i]),
            .data(port_data[i])
        );
    end

    // ports zero their data outside their own beats
    always_comb begin
        l1_rd_data = '0;
        for (int i = 0; i < l2_pkg::L1_CONNECTIONS; i++) begin
            l1_rd_data = l1_rd_data | port_data[i];
        end
    end

    l1_arbiter arbiter (
        .requests(port_request),
        .port_addr(port_addr),
        .port_rnw(port_rnw),
        .port_be(port_be),
        .port_burst(port_burst),
        .port_sub_id(port_sub_id),
        .wr_data_in(l1_wr_data),
        .request_full(req_full),
        .data_full(data_full),
        .acks(l1_ack),
        .request_push(request_push),
        .request_word(request_word),
        .wr_data_push(wr_data_push),
        .wr_data(wr_data)
    );

    l2_fifo #(
        .WIDTH(l2_pkg::L2_REQ_W),
        .DEPTH(l2_pkg::REQ_FIFO_DEPTH)
    ) req_fifo (
        .clk(clk),
        .rst(rst),
        .push(request_push),
        .push_data(request_word),
        .pop(req_pop),
        .pop_data(req_head),
        .full(req_full),
        .empty(req_empty)
    );

    l2_fifo #(
        .WIDTH(l2_pkg::DATA_W),
        .DEPTH(l2_pkg::DATA_FIFO_DEPTH)
    ) data_fifo (
        .clk(clk),
        .rst(rst),
        .push(wr_data_push),
        .push_data(wr_data),
        .pop(data_pop),
        .pop_data(data_head),
        .full(data_full),
        .empty(data_empty)
    );

    l2_memory memory (
        .clk(clk),
        .rst(rst),
        .req_word(req_head),
        .req_empty(req_empty),
        .wr_word(data_head),
        .data_empty(data_empty),
        .req_pop(req_pop),
        .data_pop(data_pop),
        .rd_data(rd_data),
        .rd_data_valid(rd_data_valid),
        .rd_sub_id(rd_sub_id)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
// ----------------------------------------------------------
// 40 ns clock, rst held high for the first 10 rising edges
// rst drops 1 ns after an edge, like the other inputs
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== verification/l2_subsystem_sva.sv ====
// ----------------------------------------------------------
// bound into l2_subsystem, checks arbitration and return routing
// ----------------------------------------------------------
`timescale 1ns/1ps

module l2_subsystem_sva (
    input logic                                 clk,
    input logic                                 rst,
    input logic [l2_pkg::L1_CONNECTIONS-1:0]    l1_request,
    input logic [l2_pkg::L1_CONNECTIONS-1:0]    l1_ack,
    input logic [l2_pkg::L1_CONNECTIONS-1:0]    l1_data_valid,
    input logic                                 request_push,
    input logic                                 req_full,
    input logic                                 wr_data_push,
    input logic                                 data_full
);

    ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(l1_ack))
        else $error("more than one ack at a time");

    ack_requesting: assert property (@(posedge clk) disable iff (rst)
        (l1_ack & ~l1_request) == '0)
        else $error("ack to a port that is not requesting");

    valid_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(l1_data_valid))
        else $error("data_valid on more than one port");

    no_req_overflow: assert property (@(posedge clk) disable iff (rst)
        !(request_push && req_full))
        else $error("request pushed while the request FIFO is full");

    no_data_overflow: assert property (@(posedge clk) disable iff (rst)
        !(wr_data_push && data_full))
        else $error("write data pushed while the data FIFO is full");

endmodule

bind l2_subsystem l2_subsystem_sva sva_inst (
    .clk(clk),
    .rst(rst),
    .l1_request(l1_request),
    .l1_ack(l1_ack),
    .l1_data_valid(l1_data_valid),
    .request_push(request_push),
    .req_full(req_full),
    .wr_data_push(wr_data_push),
    .data_full(data_full)
);

// ==== verification/l2_subsystem_tb.sv ====
// ----------------------------------------------------------
// all reads stay inside words 0..63, written by the first test
// expected words are fixed when a request is acknowledged
// ----------------------------------------------------------
`timescale 1ns/1ps

module l2_subsystem_tb;

    localparam int NPORT = l2_pkg::L1_CONNECTIONS;
    localparam int TEST_WORDS = 64;
    localparam int FLOOD_CYCLES = 250;
    // roughly twice the summed length of all tests
    localparam int MAX_CYCLES = 4000;

    logic clk;
    logic rst;
    logic [NPORT-1:0] l1_request;
    logic [NPORT-1:0] l1_rnw;
    logic [NPORT-1:0][l2_pkg::ADDR_W-1:0] l1_addr;
    l2_pkg::l2_be_t [NPORT-1:0] l1_be;
    l2_pkg::burst_t [NPORT-1:0] l1_size;
    l2_pkg::l2_data_t l1_wr_data;
    logic [NPORT-1:0] l1_ack;
    l2_pkg::l2_data_t l1_rd_data;
    logic [NPORT-1:0] l1_data_valid;

    // shadow of the memory and the beats still owed, in return order
    l2_pkg::l2_data_t shadow [l2_pkg::MEM_WORDS];
    l2_pkg::l2_data_t exp_data_q [$];
    l2_pkg::sub_id_t exp_port_q [$];

    string test_name = "reset_idle";
    integer seed = 23838;
    int cycle_count = 0;
    int full_cycles = 0;
    logic [NPORT-1:0] exp_mask;
    logic [NPORT-1:0] acked;

    tb_clock_gen clock_gen (
        .clk(clk),
        .rst(rst)
    );

    l2_subsystem dut (
        .clk(clk),
        .rst(rst),
        .l1_request(l1_request),
        .l1_rnw(l1_rnw),
        .l1_addr(l1_addr),
        .l1_be(l1_be),
        .l1_size(l1_size),
        .l1_wr_data(l1_wr_data),
        .l1_ack(l1_ack),
        .l1_rd_data(l1_rd_data),
        .l1_data_valid(l1_data_valid)
    );

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_data(string name, l2_pkg::l2_data_t exp, l2_pkg::l2_data_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_port(string name, l2_pkg::sub_id_t exp, l2_pkg::sub_id_t act);
        if (exp !== act) begin
            $display("ERR %s expected port %0d actual port %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_mask(string name, logic [NPORT-1:0] exp, logic [NPORT-1:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // byte address to word address, offset bits dropped
    function automatic l2_pkg::l2_addr_t word_of(logic [l2_pkg::ADDR_W-1:0] addr);
        return l2_pkg::l2_addr_t'(addr >> 2);
    endfunction

    // burst beat k reads word addr+k, wrapping on the memory depth
    function automatic l2_pkg::l2_data_t expected_read(l2_pkg::l2_addr_t addr, int offset);
        l2_pkg::l2_addr_t word;
        word = addr + l2_pkg::l2_addr_t'(offset);
        return shadow[int'(word) % l2_pkg::MEM_WORDS];
    endfunction

    function automatic void apply_write(l2_pkg::l2_addr_t addr, l2_pkg::l2_be_t be,
                                        l2_pkg::l2_data_t data);
        int idx;
        idx = int'(addr) % l2_pkg::MEM_WORDS;
        for (int b = 0; b < l2_pkg::BE_W; b++) begin
            if (be[b]) begin
                shadow[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endfunction

    function automatic l2_pkg::sub_id_t port_of(logic [NPORT-1:0] valid);
        l2_pkg::sub_id_t id;
        id = '0;
        for (int i = NPORT - 1; i >= 0; i--) begin
            if (valid[i]) begin
                id = l2_pkg::sub_id_t'(i);
            end
        end
        return id;
    endfunction

    task automatic post_read(int p, int word, int size);
        int lo;
        lo = {$random(seed)} % 4;
        l1_request[p] = 1'b1;
        l1_rnw[p] = 1'b1;
        l1_addr[p] = word * 4 + lo;
        l1_be[p] = l2_pkg::l2_be_t'($random(seed));
        l1_size[p] = l2_pkg::burst_t'(size);
    endtask

    // random size field, a write is still one word
    task automatic post_write(int word, l2_pkg::l2_be_t be, l2_pkg::l2_data_t data);
        int lo;
        lo = {$random(seed)} % 4;
        l1_request[l2_pkg::L1_DCACHE_ID] = 1'b1;
        l1_rnw[l2_pkg::L1_DCACHE_ID] = 1'b0;
        l1_addr[l2_pkg::L1_DCACHE_ID] = word * 4 + lo;
        l1_be[l2_pkg::L1_DCACHE_ID] = be;
        l1_size[l2_pkg::L1_DCACHE_ID] = l2_pkg::burst_t'($random(seed));
        l1_wr_data = data;
    endtask

    task automatic post_random(int p);
        if (p == l2_pkg::L1_DCACHE_ID && ({$random(seed)} % 2) == 0) begin
            post_write({$random(seed)} % TEST_WORDS, l2_pkg::l2_be_t'($random(seed)),
                       l2_pkg::l2_data_t'($random(seed)));
        end else begin
            post_read(p, {$random(seed)} % (TEST_WORDS - 7), {$random(seed)} % 8);
        end
    endtask

    // one clock, acks must stay low while a FIFO is full
    task automatic advance();
        logic [NPORT-1:0] taken;
        @(negedge clk);
        if (dut.req_full || dut.data_full) begin
            full_cycles++;
            check_mask({test_name, "_backpressure"}, '0, l1_ack);
        end
        taken = l1_request & l1_ack;
        @(posedge clk);
        #1;
        l1_request = l1_request & ~taken;
    endtask

    task automatic drain();
        while (l1_request != '0) begin
            advance();
        end
    endtask

    task automatic wait_quiet();
        drain();
        while (exp_data_q.size() != 0) begin
            advance();
        end
        repeat (4) advance();
    endtask

    // compare process, mid cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (l1_data_valid != '0) begin
                if (exp_data_q.size() == 0) begin
                    $display("data_valid seen with no read outstanding in %s", test_name);
                    stop_run();
                end else begin
                    check_port(test_name, exp_port_q.pop_front(), port_of(l1_data_valid));
                    check_data(test_name, exp_data_q.pop_front(), l1_rd_data);
                end
            end
            for (int p = 0; p < NPORT; p++) begin
                if (l1_request[p] && l1_ack[p]) begin
                    if (l1_rnw[p]) begin
                        for (int k = 0; k <= int'(l1_size[p]); k++) begin
                            exp_port_q.push_back(l2_pkg::sub_id_t'(p));
                            exp_data_q.push_back(expected_read(word_of(l1_addr[p]), k));
                        end
                    end else begin
                        apply_write(word_of(l1_addr[p]), l1_be[p], l1_wr_data);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    initial begin
        l1_request = '0;
        l1_rnw = '0;
        l1_addr = '0;
        l1_be = '0;
        l1_size = '0;
        l1_wr_data = '0;
        @(negedge rst);

        // quiet after reset
        repeat (5) begin
            @(negedge clk);
            check_mask("reset_idle_ack", '0, l1_ack);
            check_mask("reset_idle_valid", '0, l1_data_valid);
        end
        @(posedge clk);
        #1;

        test_name = "write_then_read";
        for (int w = 0; w < TEST_WORDS; w++) begin
            post_write(w, 4'hf, l2_pkg::l2_data_t'($random(seed)));
            drain();
        end
        for (int p = 0; p < NPORT; p++) begin
            for (int j = 0; j < TEST_WORDS / NPORT; j++) begin
                post_read(p, p * (TEST_WORDS / NPORT) + j, 0);
                drain();
            end
        end
        wait_quiet();

        test_name = "burst_read";
        for (int p = 0; p < NPORT; p++) begin
            for (int s = 0; s < 8; s++) begin
                post_read(p, {$random(seed)} % (TEST_WORDS - 7), s);
                drain();
            end
        end
        wait_quiet();

        test_name = "partial_write";
        for (int i = 0; i < 16; i++) begin
            post_write({$random(seed)} % TEST_WORDS, l2_pkg::l2_be_t'($random(seed)),
                       l2_pkg::l2_data_t'($random(seed)));
            drain();
            post_read(i % NPORT, int'(word_of(l1_addr[l2_pkg::L1_DCACHE_ID])), 0);
            drain();
        end
        wait_quiet();

        // second round has the data cache writing
        test_name = "priority_order";
        for (int round = 0; round < 2; round++) begin
            for (int p = 0; p < NPORT; p++) begin
                post_random(p);
            end
            if (round == 1) begin
                post_write({$random(seed)} % TEST_WORDS, 4'hf, l2_pkg::l2_data_t'($random(seed)));
            end
            for (int k = 0; k < NPORT; k++) begin
                @(negedge clk);
                exp_mask = '0;
                exp_mask[k] = 1'b1;
                check_mask(test_name, exp_mask, l1_ack);
                acked = l1_request & l1_ack;
                @(posedge clk);
                #1;
                l1_request = l1_request & ~acked;
            end
            wait_quiet();
        end

        test_name = "flood";
        full_cycles = 0;
        for (int c = 0; c < FLOOD_CYCLES; c++) begin
            for (int p = 0; p < NPORT; p++) begin
                if (!l1_request[p] && ({$random(seed)} % 2) == 1) begin
                    post_random(p);
                end
            end
            advance();
        end
        wait_quiet();
        if (full_cycles == 0) begin
            $display("flood never filled a FIFO, back-pressure not exercised");
            stop_run();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== l2_subsystem.f ====
common/l2_pkg.sv
hdl/l1_request_port.sv
l1_arbiter/l1_arbiter.sv
hdl/l2_fifo.sv
l2_memory/l2_memory.sv
hdl/l2_subsystem.sv
verification/tb_clock_gen.sv
verification/l2_subsystem_sva.sv
verification/l2_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the L2 subsystem testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module l2_subsystem_tb \
    -f l2_subsystem.f \
    -o sim_l2_subsystem || exit 1

out=$(./obj_dir/sim_l2_subsystem)
echo "$out"
echo "$out" | grep -qF '>>> PASS' && echo "simulation passed" || { echo "simulation failed"; exit 1; }
